// ==== verilog/ccip_params.svh ====
// Request path sizing macros

`ifndef CCIP_PARAMS_SVH
`define CCIP_PARAMS_SVH

// ==============================
// Data path
// ==============================

// One memory word moves per request
`define CCIP_DATA_WIDTH 64

// One enable bit for each data byte
`define CCIP_BE_WIDTH 8

// Line address into the local memory, 1024 words deep
`define CCIP_ADDR_WIDTH 10

// Requester tag that comes back unchanged in the response
`define CCIP_MDATA_WIDTH 16

// ==============================
// Request buffering
// ==============================

// Sixteen entries in the request FIFO
`define CCIP_FIFO_DEPTH_RADIX 4

// Free entries left when almost-full rises
`define CCIP_ALM_FULL_SLACK 4

`endif

// ==== verilog/ccip_pkg.sv ====
// Request path types

`include "ccip_params.svh"

package ccip_pkg;

	// ==============================
	// Request header word
	// ==============================

	// Kind bit selects how the header word is decoded
	typedef enum logic
	{
		REQ_RD = 1'b0,
		REQ_WR = 1'b1
	} t_req_kind;

	// Read view of the header
	// The reserved field is as wide as the write byte enables so both views match in size
	typedef struct packed
	{
		logic [`CCIP_ADDR_WIDTH-1:0]  addr;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
		logic [`CCIP_BE_WIDTH-1:0]    rsvd;
	} t_rd_hdr;

	// Write view of the header
	typedef struct packed
	{
		logic [`CCIP_BE_WIDTH-1:0]    byte_en;
		logic [`CCIP_ADDR_WIDTH-1:0]  addr;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
	} t_wr_hdr;

	// One 34 bit word with two decodings
	typedef union packed
	{
		t_rd_hdr rd;
		t_wr_hdr wr;
	} t_req_hdr_u;

	// One FIFO entry of 99 bits
	typedef struct packed
	{
		t_req_kind                   kind;
		t_req_hdr_u                  hdr;
		logic [`CCIP_DATA_WIDTH-1:0] data;
	} t_tx_req;

	// ==============================
	// Requester side channels
	// ==============================

	// Read request on c0
	typedef struct packed
	{
		logic                         valid;
		logic [`CCIP_ADDR_WIDTH-1:0]  addr;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
	} t_c0_tx;

	// Write request on c1 with its byte enables and payload
	typedef struct packed
	{
		logic                         valid;
		logic [`CCIP_ADDR_WIDTH-1:0]  addr;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
		logic [`CCIP_BE_WIDTH-1:0]    byte_en;
		logic [`CCIP_DATA_WIDTH-1:0]  data;
	} t_c1_tx;

	typedef struct packed
	{
		t_c0_tx c0;
		t_c1_tx c1;
	} t_ccip_tx;

	// Read response carrying the stored word
	typedef struct packed
	{
		logic                         valid;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
		logic [`CCIP_DATA_WIDTH-1:0]  data;
	} t_c0_rx;

	// Write acknowledgement
	typedef struct packed
	{
		logic                         valid;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
	} t_c1_rx;

	// Responses and the throttle flag back toward the requester
	typedef struct packed
	{
		t_c0_rx c0;
		t_c1_rx c1;
		logic   tx_alm_full;
	} t_ccip_rx;

endpackage

// ==== verilog/req_hdr_stage.sv ====
// Request header stage

`timescale 1ns/1ns

`include "ccip_params.svh"

module req_hdr_stage (
	input  logic               pClk,
	input  logic               rst_n,
	input  ccip_pkg::t_ccip_tx tx,
	output ccip_pkg::t_tx_req  req,
	output logic               req_valid
);

	import ccip_pkg::*;

	// Combinational image of the request before it is registered
	t_tx_req next_req;
	logic    any_valid;

	// Requests cannot be refused so any valid channel produces an entry
	assign any_valid = tx.c0.valid | tx.c1.valid;

	// ==============================
	// Header packing
	// ==============================

	// Channel c1 carries writes and channel c0 carries reads
	// Only one of them is valid in a cycle, so c1 simply takes priority here
	always_comb
	begin
		next_req = '0;
		if (tx.c1.valid)
		begin
			next_req.kind           = REQ_WR;
			next_req.hdr.wr.byte_en = tx.c1.byte_en;
			next_req.hdr.wr.addr    = tx.c1.addr;
			next_req.hdr.wr.mdata   = tx.c1.mdata;
			next_req.data           = tx.c1.data;
		end
		else
		begin
			next_req.kind         = REQ_RD;
			next_req.hdr.rd.addr  = tx.c0.addr;
			next_req.hdr.rd.mdata = tx.c0.mdata;
			// Reads carry no payload and keep the reserved field clear
			next_req.hdr.rd.rsvd  = '0;
			next_req.data         = '0;
		end
	end

	// ==============================
	// Output register
	// ==============================

	// Valid flag is the only control state of this stage
	always_ff @(posedge pClk or negedge rst_n)
	begin
		if (!rst_n)
			req_valid <= 1'b0;
		else
			req_valid <= any_valid;
	end

	// Payload only loads when a request arrives
	always_ff @(posedge pClk)
	begin
		if (any_valid)
			req <= next_req;
	end

	// The requester may never drive a read and a write in the same cycle
	// A second request would be lost since this stage holds one entry per cycle
	a_one_channel: assert property (
		@(posedge pClk) disable iff (!rst_n)
		!(tx.c0.valid && tx.c1.valid)
	) else $error("req_hdr_stage saw c0 and c1 valid together");

endmodule

// ==== verilog/tx_req_fifo.sv ====
// Request FIFO with almost-full

`timescale 1ns/1ns

`include "ccip_params.svh"

module tx_req_fifo #(
	parameter int DEPTH_RADIX = `CCIP_FIFO_DEPTH_RADIX
) (
	input  logic              pClk,
	input  logic              rst_n,
	input  ccip_pkg::t_tx_req req,
	input  logic              req_valid,
	input  logic              pop,
	output ccip_pkg::t_tx_req head,
	output logic              head_valid,
	output logic              alm_full
);

	import ccip_pkg::*;

	localparam int DEPTH = 1 << DEPTH_RADIX;

	// Count is one bit wider than the pointers so a full buffer is distinct from empty
	localparam logic [DEPTH_RADIX:0] FULL_COUNT = (DEPTH_RADIX+1)'(DEPTH);

	// Almost-full threshold leaves room for the producer register
	// and the one cycle the requester needs to react
	localparam logic [DEPTH_RADIX:0] ALM_FULL_COUNT =
		(DEPTH_RADIX+1)'(DEPTH - `CCIP_ALM_FULL_SLACK);

	// ==============================
	// Storage and pointers
	// ==============================

	t_tx_req                entries [DEPTH];
	logic [DEPTH_RADIX-1:0] wr_ptr;
	logic [DEPTH_RADIX-1:0] rd_ptr;
	logic [DEPTH_RADIX:0]   count;

	// New entries land at the write pointer
	always_ff @(posedge pClk)
	begin
		if (req_valid)
			entries[wr_ptr] <= req;
	end

	// Pointers wrap naturally at the power of two depth
	always_ff @(posedge pClk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (req_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			// A write and a pop in the same cycle leave the count alone
			case ({req_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ==============================
	// Head and status
	// ==============================

	// Show-ahead head, valid right after the edge that wrote it
	assign head       = entries[rd_ptr];
	assign head_valid = (count != '0);

	// Driven straight from the registered count so it never glitches
	assign alm_full = (count >= ALM_FULL_COUNT);

	// The slack must keep a well behaved requester from ever overrunning the buffer
	a_no_overflow: assert property (
		@(posedge pClk) disable iff (!rst_n)
		req_valid |-> (count < FULL_COUNT)
	) else $error("tx_req_fifo written while full");

	// The memory model may only pop an entry that exists
	a_no_underflow: assert property (
		@(posedge pClk) disable iff (!rst_n)
		pop |-> head_valid
	) else $error("tx_req_fifo popped while empty");

endmodule

// ==== verilog/mem_sim_model.sv ====
// Local memory model

`timescale 1ns/1ns

`include "ccip_params.svh"

module mem_sim_model (
	input  logic              pClk,
	input  logic              rst_n,
	input  ccip_pkg::t_tx_req head,
	input  logic              head_valid,
	input  logic              mem_waitrequest,
	output logic              pop,
	output ccip_pkg::t_c0_rx  c0_rx,
	output ccip_pkg::t_c1_rx  c1_rx
);

	import ccip_pkg::*;

	localparam int MEM_WORDS  = 1 << `CCIP_ADDR_WIDTH;
	localparam int BYTE_WIDTH = `CCIP_DATA_WIDTH / `CCIP_BE_WIDTH;

	// ==============================
	// Request decode
	// ==============================

	logic [`CCIP_DATA_WIDTH-1:0]  mem [MEM_WORDS];
	logic                         rd_pop;
	logic                         wr_pop;
	logic [`CCIP_MDATA_WIDTH-1:0] pop_mdata;

	// Nothing is taken while wait-request is high
	assign pop = head_valid & ~mem_waitrequest;

	assign rd_pop = pop && (head.kind == REQ_RD);
	assign wr_pop = pop && (head.kind == REQ_WR);

	// The tag sits at a different place in each header view
	assign pop_mdata = (head.kind == REQ_RD) ? head.hdr.rd.mdata : head.hdr.wr.mdata;

	// ==============================
	// Memory array
	// ==============================

	// Writes merge byte by byte under the enables
	always_ff @(posedge pClk)
	begin
		if (wr_pop)
		begin
			for (int b = 0; b < `CCIP_BE_WIDTH; b++)
			begin
				if (head.hdr.wr.byte_en[b])
					mem[head.hdr.wr.addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
						head.data[b*BYTE_WIDTH +: BYTE_WIDTH];
			end
		end
	end

	// ==============================
	// Responses
	// ==============================

	logic                         rd_rsp_valid;
	logic                         wr_rsp_valid;
	logic [`CCIP_MDATA_WIDTH-1:0] rsp_mdata;
	logic [`CCIP_DATA_WIDTH-1:0]  rd_data;

	// Each response valid follows its pop by one cycle
	always_ff @(posedge pClk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_rsp_valid <= 1'b0;
			wr_rsp_valid <= 1'b0;
		end
		else
		begin
			rd_rsp_valid <= rd_pop;
			wr_rsp_valid <= wr_pop;
		end
	end

	// Synchronous read, so a write popped one cycle earlier is already visible
	always_ff @(posedge pClk)
	begin
		if (pop)
			rsp_mdata <= pop_mdata;
		if (rd_pop)
			rd_data <= mem[head.hdr.rd.addr];
	end

	always_comb
	begin
		c0_rx.valid = rd_rsp_valid;
		c0_rx.mdata = rsp_mdata;
		c0_rx.data  = rd_data;
		c1_rx.valid = wr_rsp_valid;
		c1_rx.mdata = rsp_mdata;
	end

	// Responses never overlap since only one request is served per cycle
	a_rsp_onehot0: assert property (
		@(posedge pClk) disable iff (!rst_n)
		$onehot0({c0_rx.valid, c1_rx.valid})
	) else $error("mem_sim_model drove both response valids");

endmodule

// ==== verilog/ccip_mem_afu.sv ====
// Memory request path top

`timescale 1ns/1ns

`include "ccip_params.svh"

module ccip_mem_afu (
	input  logic               pClk,
	input  logic               rst_n,
	input  ccip_pkg::t_ccip_tx sTx,
	input  logic               mem_waitrequest,
	output ccip_pkg::t_ccip_rx sRx
);

	import ccip_pkg::*;

	// ==============================
	// Internal wiring
	// ==============================

	// Header stage to FIFO
	t_tx_req req;
	logic    req_valid;

	// FIFO to memory model, head is show-ahead
	t_tx_req head;
	logic    head_valid;
	logic    pop;
	logic    alm_full;

	// Memory model responses
	t_c0_rx  c0_rx;
	t_c1_rx  c1_rx;

	// Producer packs each request into one header word
	req_hdr_stage u_req_hdr_stage (
		.pClk      (pClk),
		.rst_n     (rst_n),
		.tx        (sTx),
		.req       (req),
		.req_valid (req_valid)
	);

	// Buffer keeps requests in issue order and throttles the requester
	tx_req_fifo #(
		.DEPTH_RADIX (`CCIP_FIFO_DEPTH_RADIX)
	) u_tx_req_fifo (
		.pClk       (pClk),
		.rst_n      (rst_n),
		.req        (req),
		.req_valid  (req_valid),
		.pop        (pop),
		.head       (head),
		.head_valid (head_valid),
		.alm_full   (alm_full)
	);

	// Consumer serves one request per cycle unless held off
	mem_sim_model u_mem_sim_model (
		.pClk            (pClk),
		.rst_n           (rst_n),
		.head            (head),
		.head_valid      (head_valid),
		.mem_waitrequest (mem_waitrequest),
		.pop             (pop),
		.c0_rx           (c0_rx),
		.c1_rx           (c1_rx)
	);

	assign sRx.c0          = c0_rx;
	assign sRx.c1          = c1_rx;
	assign sRx.tx_alm_full = alm_full;

endmodule

// ==== tests/tb_ccip_mem_afu.sv ====
// Memory request path testbench

`timescale 1ns/1ns

`include "ccip_params.svh"

module tb_ccip_mem_afu;

	import ccip_pkg::*;

	// ==============================
	// Run length
	// ==============================

	// Reset read, 64 writes and reads, 32 merge triples, the random mix and the stall phase
	localparam int TOTAL_REQ   = 1 + 128 + 96 + 200 + 60;
	localparam int DRAIN_LIMIT = 2000;

	// Expected response, recorded when its request is issued
	typedef struct packed
	{
		t_req_kind                    kind;
		logic [`CCIP_MDATA_WIDTH-1:0] mdata;
		logic [`CCIP_DATA_WIDTH-1:0]  data;
		logic [`CCIP_DATA_WIDTH-1:0]  mask;
	} exp_rsp_t;

	logic     clk;
	logic     rst_n;
	t_ccip_tx tx;
	t_ccip_rx rx;
	logic     mem_waitrequest;

	// Reference memory and a per byte record of what was ever written
	logic [`CCIP_DATA_WIDTH-1:0]  ref_mem [1 << `CCIP_ADDR_WIDTH];
	logic [`CCIP_BE_WIDTH-1:0]    wr_mask [1 << `CCIP_ADDR_WIDTH];
	logic [`CCIP_ADDR_WIDTH-1:0]  line_addr [64];
	exp_rsp_t                     exp_q [$];
	logic [`CCIP_MDATA_WIDTH-1:0] next_tag;
	string                        cur_test;
	int                           mismatch_count;
	int                           fail_count;
	int                           rsp_count;
	logic                         alm_seen;
	logic                         alm_rose;
	logic                         stall_done;

	ccip_mem_afu dut_i (
		.pClk            (clk),
		.rst_n           (rst_n),
		.sTx             (tx),
		.mem_waitrequest (mem_waitrequest),
		.sRx             (rx)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Throttle flag as the requester saw it at the last rising edge
	always @(posedge clk)
	begin
		alm_seen <= rx.tx_alm_full;
		if (rx.tx_alm_full)
			alm_rose <= 1'b1;
	end

	// Widen byte enables to a bit mask over the data word
	function automatic logic [`CCIP_DATA_WIDTH-1:0] expand_be(input logic [`CCIP_BE_WIDTH-1:0] be);
		logic [`CCIP_DATA_WIDTH-1:0] m;
		for (int b = 0; b < `CCIP_BE_WIDTH; b++)
			m[b*8 +: 8] = {8{be[b]}};
		return m;
	endfunction

	// ==============================
	// Requester
	// ==============================

	// Wait for a falling edge on which issuing is allowed
	task automatic wait_for_slot();
		@(negedge clk);
		tx = '0;
		while (alm_seen)
			@(negedge clk);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		tx = '0;
	endtask

	task automatic issue_read(input logic [`CCIP_ADDR_WIDTH-1:0] addr);
		exp_rsp_t e;
		wait_for_slot();
		tx.c0.valid = 1'b1;
		tx.c0.addr  = addr;
		tx.c0.mdata = next_tag;
		e.kind  = REQ_RD;
		e.mdata = next_tag;
		e.data  = ref_mem[addr];
		// Bytes never written hold no defined value and are not compared
		e.mask  = expand_be(wr_mask[addr]);
		exp_q.push_back(e);
		next_tag++;
	endtask

	task automatic issue_write(input logic [`CCIP_ADDR_WIDTH-1:0] addr,
		input logic [`CCIP_BE_WIDTH-1:0] be, input logic [`CCIP_DATA_WIDTH-1:0] data);
		exp_rsp_t e;
		logic [`CCIP_DATA_WIDTH-1:0] m;
		wait_for_slot();
		tx.c1.valid   = 1'b1;
		tx.c1.addr    = addr;
		tx.c1.mdata   = next_tag;
		tx.c1.byte_en = be;
		tx.c1.data    = data;
		// Requests are served in issue order so the model can merge right away
		m = expand_be(be);
		ref_mem[addr] = (ref_mem[addr] & ~m) | (data & m);
		wr_mask[addr] = wr_mask[addr] | be;
		e.kind  = REQ_WR;
		e.mdata = next_tag;
		e.data  = '0;
		e.mask  = '0;
		exp_q.push_back(e);
		next_tag++;
	endtask

	task automatic issue_random(input int addr_range);
		if ($urandom % 2)
			issue_write($urandom % addr_range, $urandom, {$urandom, $urandom});
		else
			issue_read($urandom % addr_range);
	endtask

	// Stop issuing and wait until every outstanding response came back
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		idle_cycle();
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (exp_q.size() == 0)
		else
		begin
			fail_count++;
			$display("%s: %0d responses never arrived", cur_test, exp_q.size());
		end
	endtask

	// ==============================
	// Response scoreboard
	// ==============================

	// Outputs are registered, so they are stable at the falling edge
	always @(negedge clk)
	begin
		exp_rsp_t got;
		t_req_kind act_kind;
		logic [`CCIP_MDATA_WIDTH-1:0] act_mdata;
		if (rst_n && (rx.c0.valid || rx.c1.valid))
		begin
			rsp_count++;
			assert (!(rx.c0.valid && rx.c1.valid))
			else
			begin
				fail_count++;
				$display("%s: read response and write ack in the same cycle", cur_test);
			end
			assert (exp_q.size() != 0)
			else
			begin
				fail_count++;
				$display("%s: response arrived with no request outstanding", cur_test);
			end
			if (exp_q.size() != 0)
			begin
				got = exp_q.pop_front();
				act_kind  = rx.c1.valid ? REQ_WR : REQ_RD;
				act_mdata = rx.c1.valid ? rx.c1.mdata : rx.c0.mdata;
				assert (act_kind == got.kind)
				else
				begin
					mismatch_count++;
					$display("MISMATCH %s kind: expected %s actual %s",
						cur_test, got.kind.name(), act_kind.name());
				end
				assert (act_mdata == got.mdata)
				else
				begin
					mismatch_count++;
					$display("MISMATCH %s mdata: expected %h actual %h",
						cur_test, got.mdata, act_mdata);
				end
				assert (!rx.c0.valid || ((rx.c0.data & got.mask) === (got.data & got.mask)))
				else
				begin
					mismatch_count++;
					$display("MISMATCH %s data: expected %h actual %h (mask %h)",
						cur_test, got.data, rx.c0.data, got.mask);
				end
			end
		end
	end

	// Ends a run that stops making progress
	initial
	begin
		repeat (TOTAL_REQ * 40) @(posedge clk);
		$display("Watchdog expired after %0d cycles with %0d responses outstanding",
			TOTAL_REQ * 40, exp_q.size());
		$display("TB FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		void'($urandom(32'h2707));
		tx = '0;
		rst_n = 1'b0;
		mem_waitrequest = 1'b0;
		next_tag = '0;
		mismatch_count = 0;
		fail_count = 0;
		rsp_count = 0;
		alm_rose = 1'b0;
		stall_done = 1'b0;
		for (int i = 0; i < (1 << `CCIP_ADDR_WIDTH); i++)
			wr_mask[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Quiet outputs after reset, then a read straight away
		cur_test = "reset_read";
		assert (!rx.tx_alm_full && !rx.c0.valid && !rx.c1.valid)
		else
		begin
			fail_count++;
			$display("reset_read: outputs not idle after reset");
		end
		issue_read($urandom % 1024);
		wait_drain();

		// The reads go back to the same lines that were just written
		cur_test = "full_write_read";
		for (int i = 0; i < 64; i++)
		begin
			line_addr[i] = $urandom % 1024;
			issue_write(line_addr[i], 8'hff, {$urandom, $urandom});
		end
		for (int i = 0; i < 64; i++)
			issue_read(line_addr[i]);
		wait_drain();

		// Each line gets a full word first so every merged byte is checked
		cur_test = "byte_merge";
		for (int i = 0; i < 32; i++)
		begin
			logic [`CCIP_ADDR_WIDTH-1:0] a;
			a = $urandom % 1024;
			issue_write(a, 8'hff, {$urandom, $urandom});
			issue_write(a, $urandom, {$urandom, $urandom});
			issue_read(a);
		end
		wait_drain();

		cur_test = "random_mix";
		for (int i = 0; i < 200; i++)
		begin
			issue_random(64);
			if ($urandom % 4 == 0)
				idle_cycle();
		end
		wait_drain();

		// Long wait-request stretches fill the FIFO until the requester is throttled
		cur_test = "waitreq_backpressure";
		alm_rose = 1'b0;
		fork
			begin
				while (!stall_done)
				begin
					@(negedge clk);
					mem_waitrequest = 1'b1;
					repeat (50) @(negedge clk);
					mem_waitrequest = 1'b0;
					repeat (8) @(negedge clk);
				end
			end
			begin
				for (int i = 0; i < 60; i++)
					issue_random(64);
				// The last request must not stay on the bus while the stall thread finishes
				idle_cycle();
				stall_done = 1'b1;
			end
		join
		wait_drain();
		assert (alm_rose)
		else
		begin
			fail_count++;
			$display("waitreq_backpressure: tx_alm_full never rose");
		end

		repeat (10) @(negedge clk);
		$display("Done: %0d responses, %0d mismatches, %0d other errors",
			rsp_count, mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/ccip_pkg.sv
verilog/req_hdr_stage.sv
verilog/tx_req_fifo.sv
verilog/mem_sim_model.sv
verilog/ccip_mem_afu.sv
tests/tb_ccip_mem_afu.sv
